/* bench/bridge_properties.sv */
`timescale 1ns/1ps

module bridge_properties (
    input logic             r_clk,
    input logic             a_dirClr,
    input logic             sample_avail,
    input logic             event_avail,
    input logic             out_hold,
    input logic             sample_pop,
    input logic             event_pop,
    input logic             out_valid,
    input merge_pkg::turn_t turn
);
    import merge_pkg::*;

    // ==================================================
    // Pop rules
    // ==================================================

    // Never pop an empty FIFO
    sample_pop_needs_data: assert property (@(posedge r_clk) disable iff (a_dirClr)
        sample_pop |-> sample_avail)
        else $error("sample_pop issued without sample_avail");
    event_pop_needs_data: assert property (@(posedge r_clk) disable iff (a_dirClr)
        event_pop |-> event_avail)
        else $error("event_pop issued without event_avail");

    // Back-pressure blocks both channels
    no_pop_on_hold: assert property (@(posedge r_clk) disable iff (a_dirClr)
        out_hold |-> !(sample_pop || event_pop))
        else $error("pop issued while out_hold is high");

    // One channel per cycle
    single_pop: assert property (@(posedge r_clk) disable iff (a_dirClr)
        !(sample_pop && event_pop))
        else $error("sample_pop and event_pop high together");

    // ==================================================
    // Output timing
    // ==================================================

    // Registered output, one cycle behind the pop
    pop_then_valid: assert property (@(posedge r_clk) disable iff (a_dirClr)
        (sample_pop || event_pop) |=> out_valid)
        else $error("pop not followed by out_valid");

    // Each tie hands priority to the other channel
    tie_flips_turn: assert property (@(posedge r_clk) disable iff (a_dirClr)
        (sample_avail && event_avail && !out_hold) |=> (turn != $past(turn)))
        else $error("turn not handed over after a tie");

endmodule

bind stream_merger bridge_properties i_merger_props (
    .r_clk        (r_clk),
    .a_dirClr     (a_dirClr),
    .sample_avail (sample_avail),
    .event_avail  (event_avail),
    .out_hold     (out_hold),
    .sample_pop   (sample_pop),
    .event_pop    (event_pop),
    .out_valid    (out_valid),
    .turn         (turn)
);

/* bench/bridge_tb.sv */
`timescale 1ns/1ps

`include "fifo_config.svh"

module bridge_tb;
    import payload_pkg::*;
    import merge_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'd31;
    // Run budget per command line, plus fixed slack
    localparam int CYCLES_PER_CMD = 40;
    localparam int CYCLE_MARGIN   = 200;

    // DUT inputs
    logic         w_clk        = 1'b0;
    logic         r_clk        = 1'b1;
    logic         a_dirClr     = 1'b0;
    logic         sample_write = 1'b0;
    sample_word_t sample_data  = '0;
    logic         event_write  = 1'b0;
    event_word_t  event_data   = '0;
    logic         out_hold     = 1'b0;

    // DUT outputs
    logic         sample_ready;
    logic         event_ready;
    logic         out_valid;
    source_tag_t  out_tag;
    merged_word_t out_data;

    // Parsed command lines
    logic [7:0]   cmd_q [$];
    int           arg_q [$];

    // Expected words per channel
    logic [15:0]  sample_q [$];
    logic [15:0]  event_q [$];

    // Round-robin model, next winner on a tie
    source_tag_t  model_turn   = TAG_SAMPLE;
    logic         hold_prev    = 1'b0;
    int           alt_left     = 0;
    // Writes accepted while the current hold is active
    int           held_samples = 0;
    int           held_events  = 0;

    logic [15:0]  lfsr         = LFSR_SEED;
    int           cycle_count  = 0;
    int           cycle_limit  = CYCLE_MARGIN;

    // ==================================================
    // Clocks and DUT
    // ==================================================

    always #5 r_clk = ~r_clk;
    always #8 w_clk = ~w_clk;

    dual_stream_bridge i_dual_stream_bridge (
        .w_clk        (w_clk),
        .r_clk        (r_clk),
        .a_dirClr     (a_dirClr),
        .sample_write (sample_write),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .event_write  (event_write),
        .event_data   (event_data),
        .event_ready  (event_ready),
        .out_hold     (out_hold),
        .out_valid    (out_valid),
        .out_tag      (out_tag),
        .out_data     (out_data)
    );

    // ==================================================
    // Helpers
    // ==================================================

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Command letter, then a hex or decimal argument
    task automatic load_tests();
        int               fd;
        int               n;
        int               arg;
        logic [7:0]       cmd;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/bridge_tests.txt", "r");
        if (fd == 0) begin
            report_problem("Could not open bench/bridge_tests.txt");
        end
        forever begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                break;
            end
            arg = 0;
            if (cmd == "#") begin
                // Rest of a comment line
                n = $fgets(rest, fd);
            end else begin
                if (cmd == "S" || cmd == "E") begin
                    n = $fscanf(fd, " %h", arg);
                end else if (cmd == "H") begin
                    n = $fscanf(fd, " %d", arg);
                end else if (cmd != "G") begin
                    report_problem($sformatf("Unknown command '%c' in test file", cmd));
                end
                cmd_q.push_back(cmd);
                arg_q.push_back(arg);
            end
        end
        $fclose(fd);
    endtask

    // One producer write, gated by the ready level
    task automatic write_word(input logic is_event, input logic [15:0] value);
        logic [1:0] gap;
        logic       ready_now;
        int         held_now;
        gap = 2'b00;
        for (int b = 0; b < 2; b++) begin
            lfsr = next_lfsr(lfsr);
            gap  = {gap[0], lfsr[0]};
        end
        repeat (gap) @(posedge w_clk);
        // Wait for space
        @(negedge w_clk);
        ready_now = is_event ? event_ready : sample_ready;
        while (!ready_now) begin
            @(negedge w_clk);
            ready_now = is_event ? event_ready : sample_ready;
        end
        @(posedge w_clk);
        if (is_event) begin
            event_write <= 1'b1;
            event_data  <= value[11:0];
            // Zero-extended into the merged field
            event_q.push_back({4'h0, value[11:0]});
        end else begin
            sample_write <= 1'b1;
            sample_data  <= value;
            sample_q.push_back(value);
        end
        // Accept edge
        @(posedge w_clk);
        sample_write <= 1'b0;
        event_write  <= 1'b0;
        @(negedge w_clk);
        if (out_hold) begin
            if (is_event) begin
                held_events++;
                held_now  = held_events;
                ready_now = event_ready;
            end else begin
                held_samples++;
                held_now  = held_samples;
                ready_now = sample_ready;
            end
            // Nothing drains during a hold, so the FIFO is full by now
            if (held_now >= `FIFO_DEPTH) begin
                assert (!ready_now)
                    else report_mismatch($sformatf("ready still high after %0d held writes",
                                                   held_now));
            end
        end
    endtask

    task automatic release_hold(input int cycles);
        repeat (cycles) @(posedge r_clk);
        out_hold <= 1'b0;
    endtask

    task automatic run_command(input logic [7:0] cmd, input int arg);
        case (cmd)
            "S": write_word(1'b0, 16'(arg));
            "E": write_word(1'b1, 16'(arg));
            "H": begin
                @(posedge r_clk);
                out_hold     <= 1'b1;
                held_samples = 0;
                held_events  = 0;
                // Writes go on while the hold runs out
                fork
                    release_hold(arg);
                join_none
            end
            default: begin
                // Drain
                while (sample_q.size() != 0 || event_q.size() != 0) begin
                    @(negedge r_clk);
                end
            end
        endcase
    endtask

    // ==================================================
    // Scoreboard
    // ==================================================

    always @(negedge r_clk) begin
        if (!a_dirClr) begin
            if (out_valid) begin
                // out_valid trails the pop by one cycle
                assert (!hold_prev)
                    else report_mismatch("out_valid pulsed while out_hold was high");
                if (alt_left > 0) begin
                    assert (out_tag == model_turn)
                        else report_mismatch($sformatf("tag %0d breaks alternation", out_tag));
                    alt_left = alt_left - 1;
                end
                if (out_tag == TAG_SAMPLE) begin
                    assert (sample_q.size() > 0)
                        else report_problem("Extra sample word on the output");
                    assert (out_data == sample_q[0])
                        else report_mismatch($sformatf("sample got %h, expected %h",
                                                       out_data, sample_q[0]));
                    void'(sample_q.pop_front());
                end else begin
                    assert (event_q.size() > 0)
                        else report_problem("Extra event word on the output");
                    assert (out_data == event_q[0])
                        else report_mismatch($sformatf("event got %h, expected %h",
                                                       out_data, event_q[0]));
                    void'(event_q.pop_front());
                end
                // Winner hands the next tie to the other side
                model_turn = (out_tag == TAG_SAMPLE) ? TAG_EVENT : TAG_SAMPLE;
            end
            // Release: both sides hold at least k words
            if (hold_prev && !out_hold) begin
                alt_left = 2 * ((held_samples < held_events) ? held_samples : held_events);
            end
            hold_prev = out_hold;
        end
    end

    // Run limit
    always @(posedge r_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_problem($sformatf("Timeout, run not finished after %0d r_clk cycles",
                                     cycle_limit));
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        a_dirClr <= 1'b1;
        load_tests();
        cycle_limit = CYCLES_PER_CMD * cmd_q.size() + CYCLE_MARGIN;
        repeat (3) begin
            @(negedge r_clk);
            assert (!out_valid && sample_ready && event_ready)
                else report_problem("Control outputs not at reset values during reset");
        end
        @(posedge r_clk);
        a_dirClr <= 1'b0;
        @(negedge r_clk);
        assert (!out_valid && sample_ready && event_ready)
            else report_problem("Control outputs not at reset values after reset");
        for (int i = 0; i < cmd_q.size(); i++) begin
            run_command(cmd_q[i], arg_q[i]);
        end
        // Quiet tail, any stray word hits an empty queue
        repeat (20) @(negedge r_clk);
        assert (sample_q.size() == 0 && event_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_mismatch($sformatf("%0d samples and %0d events never came out",
                                      sample_q.size(), event_q.size()));
        end
    end

endmodule

/* bench/bridge_tests.txt */
# Columns: command letter, then argument. S = sample (hex, 16 bit), E = event (hex, 12 bit)
# H = hold output (decimal r_clk cycles), G = wait until output drained (no argument)
S 1234
E 0a5
S beef
E fff
S 0000
G
H 100
S 0011
E 1a1
S 0022
E 2b2
S 0033
E 3c3
G
H 100
S 8001
S 8002
S 8003
S 8004
S 8005
S 8006
S 8007
S 8008
S 8009
E 7e7
G

/* files.f */
+incdir+hw
hw/payload_pkg.sv
hw/merge_pkg.sv
hw/async_fifo.sv
hw/stream_merger.sv
hw/dual_stream_bridge.sv
bench/bridge_properties.sv
bench/bridge_tb.sv

/* hw/async_fifo.sv */
`timescale 1ns/1ps

`include "fifo_config.svh"

module async_fifo #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     w_clk,
    input  logic     r_clk,
    input  logic     a_dirClr,
    input  logic     w_write,
    input  payload_t w_data,
    output logic     w_ready,
    input  logic     r_pop,
    output logic     r_ready,
    output payload_t r_data
);
    localparam int ADDR_W = `FIFO_ADDR_BITS;
    localparam int PTR_W  = `FIFO_PTR_BITS;
    localparam int SYNC_N = `SYNC_STAGES;

    // Binary to reflected Gray
    function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
        return b ^ (b >> 1);
    endfunction

    // Storage, one entry per slot
    payload_t mem [`FIFO_DEPTH];

    // Write domain pointers
    logic [PTR_W-1:0] w_bin;
    logic [PTR_W-1:0] w_gray;
    logic [PTR_W-1:0] w_bin_next;
    logic [PTR_W-1:0] w_gray_next;
    logic             w_accept;
    logic             w_full_next;

    // Read pointer as seen from w_clk
    logic [PTR_W-1:0] rq_gray [SYNC_N];
    logic [PTR_W-1:0] r_gray_wsync;

    // Read domain pointers
    logic [PTR_W-1:0] r_bin;
    logic [PTR_W-1:0] r_gray;
    logic [PTR_W-1:0] r_bin_next;
    logic [PTR_W-1:0] r_gray_next;
    logic             r_accept;
    logic             r_empty_next;

    // Write pointer as seen from r_clk
    logic [PTR_W-1:0] wq_gray [SYNC_N];
    logic [PTR_W-1:0] w_gray_rsync;

    // ==================================================
    // Write side
    // ==================================================

    // Writes while full are dropped
    assign w_accept    = w_write && w_ready;
    assign w_bin_next  = w_bin + PTR_W'(w_accept);
    assign w_gray_next = bin2gray(w_bin_next);

    // Full when the pointers differ only in the two top Gray bits
    assign r_gray_wsync = rq_gray[SYNC_N-1];
    assign w_full_next  = (w_gray_next ==
                           {~r_gray_wsync[PTR_W-1 -: 2], r_gray_wsync[PTR_W-3:0]});

    always_ff @(posedge w_clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            w_bin   <= '0;
            w_gray  <= '0;
            // Empty after reset so space is there
            w_ready <= 1'b1;
        end else begin
            w_bin   <= w_bin_next;
            w_gray  <= w_gray_next;
            // Drops in the same cycle the last slot fills
            w_ready <= !w_full_next;
        end
    end

    // Payload store
    always_ff @(posedge w_clk) begin
        if (w_accept) begin
            mem[w_bin[ADDR_W-1:0]] <= w_data;
        end
    end

    // Read Gray pointer into w_clk
    always_ff @(posedge w_clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            for (int i = 0; i < SYNC_N; i++) begin
                rq_gray[i] <= '0;
            end
        end else begin
            rq_gray[0] <= r_gray;
            for (int i = 1; i < SYNC_N; i++) begin
                rq_gray[i] <= rq_gray[i-1];
            end
        end
    end

    // ==================================================
    // Read side
    // ==================================================

    // Pop only counts while a word is there
    assign r_accept    = r_pop && r_ready;
    assign r_bin_next  = r_bin + PTR_W'(r_accept);
    assign r_gray_next = bin2gray(r_bin_next);

    // Empty when both Gray pointers match
    assign w_gray_rsync = wq_gray[SYNC_N-1];
    assign r_empty_next = (r_gray_next == w_gray_rsync);

    always_ff @(posedge r_clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            r_bin   <= '0;
            r_gray  <= '0;
            r_ready <= 1'b0;
        end else begin
            r_bin   <= r_bin_next;
            r_gray  <= r_gray_next;
            r_ready <= !r_empty_next;
        end
    end

    // Show-ahead head word
    assign r_data = mem[r_bin[ADDR_W-1:0]];

    // Write Gray pointer into r_clk
    always_ff @(posedge r_clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            for (int i = 0; i < SYNC_N; i++) begin
                wq_gray[i] <= '0;
            end
        end else begin
            wq_gray[0] <= w_gray;
            for (int i = 1; i < SYNC_N; i++) begin
                wq_gray[i] <= wq_gray[i-1];
            end
        end
    end

endmodule

/* hw/dual_stream_bridge.sv */
`timescale 1ns/1ps

module dual_stream_bridge (
    input  logic                      w_clk,
    input  logic                      r_clk,
    input  logic                      a_dirClr,
    input  logic                      sample_write,
    input  payload_pkg::sample_word_t sample_data,
    output logic                      sample_ready,
    input  logic                      event_write,
    input  payload_pkg::event_word_t  event_data,
    output logic                      event_ready,
    input  logic                      out_hold,
    output logic                      out_valid,
    output merge_pkg::source_tag_t    out_tag,
    output payload_pkg::merged_word_t out_data
);
    import payload_pkg::*;

    // FIFO heads toward the merger
    sample_word_t sample_head;
    event_word_t  event_head;
    logic         sample_avail;
    logic         event_avail;
    logic         sample_pop;
    logic         event_pop;

    // ==================================================
    // Crossing FIFOs
    // ==================================================

    // Measurement samples
    async_fifo #(
        .payload_t (sample_word_t)
    ) i_sample_fifo (
        .w_clk    (w_clk),
        .r_clk    (r_clk),
        .a_dirClr (a_dirClr),
        .w_write  (sample_write),
        .w_data   (sample_data),
        .w_ready  (sample_ready),
        .r_pop    (sample_pop),
        .r_ready  (sample_avail),
        .r_data   (sample_head)
    );

    // Event records
    async_fifo #(
        .payload_t (event_word_t)
    ) i_event_fifo (
        .w_clk    (w_clk),
        .r_clk    (r_clk),
        .a_dirClr (a_dirClr),
        .w_write  (event_write),
        .w_data   (event_data),
        .w_ready  (event_ready),
        .r_pop    (event_pop),
        .r_ready  (event_avail),
        .r_data   (event_head)
    );

    // ==================================================
    // Round-robin merge in r_clk
    // ==================================================

    stream_merger i_merger (
        .r_clk        (r_clk),
        .a_dirClr     (a_dirClr),
        .sample_avail (sample_avail),
        .sample_head  (sample_head),
        .event_avail  (event_avail),
        .event_head   (event_head),
        .out_hold     (out_hold),
        .sample_pop   (sample_pop),
        .event_pop    (event_pop),
        .out_valid    (out_valid),
        .out_tag      (out_tag),
        .out_data     (out_data)
    );

endmodule

/* hw/fifo_config.svh */
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// ==================================================
// Async FIFO sizing
// ==================================================

// Address bits per FIFO
// Depth is always a power of two
`define FIFO_ADDR_BITS 3

// Word count derived from the address width
`define FIFO_DEPTH (1 << `FIFO_ADDR_BITS)

// Address plus one wrap bit
`define FIFO_PTR_BITS (`FIFO_ADDR_BITS + 1)

// ==================================================
// Clock crossing
// ==================================================

// Flops in each Gray pointer synchronizer
`define SYNC_STAGES 2

`endif

/* hw/merge_pkg.sv */
package merge_pkg;

    // ==================================================
    // Merger types
    // ==================================================

    // Source of each merged output word
    typedef enum logic {
        TAG_SAMPLE = 1'b0,
        TAG_EVENT  = 1'b1
    } source_tag_t;

    // Channel that wins the next tie
    typedef enum logic {
        TURN_SAMPLE = 1'b0,
        TURN_EVENT  = 1'b1
    } turn_t;

endpackage

/* hw/payload_pkg.sv */
package payload_pkg;

    // ==================================================
    // Field widths
    // ==================================================

    // Raw measurement width
    localparam int SAMPLE_BITS = 16;

    // Event record split
    localparam int EVENT_CODE_BITS = 8;
    localparam int EVENT_FLAG_BITS = 4;
    localparam int EVENT_BITS      = EVENT_CODE_BITS + EVENT_FLAG_BITS;

    // Merged output data field
    localparam int MERGED_BITS = 16;

    // ==================================================
    // Stream payloads
    // ==================================================

    // Measurement sample, passed through untouched
    typedef logic [SAMPLE_BITS-1:0] sample_word_t;

    // Event record, code in the upper bits
    typedef struct packed {
        logic [EVENT_CODE_BITS-1:0] code;
        logic [EVENT_FLAG_BITS-1:0] flags;
    } event_word_t;

    // Output data field shared by both sources
    typedef logic [MERGED_BITS-1:0] merged_word_t;

endpackage

/* hw/stream_merger.sv */
`timescale 1ns/1ps

module stream_merger (
    input  logic                      r_clk,
    input  logic                      a_dirClr,
    input  logic                      sample_avail,
    input  payload_pkg::sample_word_t sample_head,
    input  logic                      event_avail,
    input  payload_pkg::event_word_t  event_head,
    input  logic                      out_hold,
    output logic                      sample_pop,
    output logic                      event_pop,
    output logic                      out_valid,
    output merge_pkg::source_tag_t    out_tag,
    output payload_pkg::merged_word_t out_data
);
    import payload_pkg::*;
    import merge_pkg::*;

    // Round-robin state
    turn_t        turn;
    turn_t        turn_next;

    // Word selected this cycle
    merged_word_t pick_data;
    source_tag_t  pick_tag;

    // ==================================================
    // Arbitration
    // ==================================================

    // Turn only matters when both sides have data
    assign sample_pop = !out_hold && sample_avail &&
                        (!event_avail || (turn == TURN_SAMPLE));
    assign event_pop  = !out_hold && event_avail &&
                        (!sample_avail || (turn == TURN_EVENT));

    // Winner hands priority to the other channel
    always_comb begin
        turn_next = turn;
        if (sample_pop) begin
            turn_next = TURN_EVENT;
        end else if (event_pop) begin
            turn_next = TURN_SAMPLE;
        end
    end

    // Tag and widen the chosen head
    always_comb begin
        if (sample_pop) begin
            pick_tag  = TAG_SAMPLE;
            pick_data = merged_word_t'(sample_head);
        end else begin
            pick_tag  = TAG_EVENT;
            // Event zero-extended into the data field
            pick_data = {{(MERGED_BITS - EVENT_BITS){1'b0}}, event_head};
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge r_clk or posedge a_dirClr) begin
        if (a_dirClr) begin
            turn      <= TURN_SAMPLE;
            out_valid <= 1'b0;
        end else begin
            turn      <= turn_next;
            // One pulse per popped word
            out_valid <= sample_pop || event_pop;
        end
    end

    // Payload only loads on a pop
    always_ff @(posedge r_clk) begin
        if (sample_pop || event_pop) begin
            out_tag  <= pick_tag;
            out_data <= pick_data;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module bridge_tb -f files.f -o bridge_sim

# Nonzero exit on $fatal or a failed assertion
./obj_dir/bridge_sim
